/* vlog.f */
+incdir+.
alu_pkg.sv
muldiv_pkg.sv
alu_shifter.sv
alu_core.sv
mul_unit.sv
div_unit.sv
exec_unit.sv
tb_exec_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module tb_exec_unit
  import alu_pkg::*, muldiv_pkg::*;
();

  localparam int N_ALU_PER  = 16;
  localparam int N_SHIFT    = 3 * 64 * 2;
  localparam int N_MD_DIR   = 8 * 4;
  localparam int N_MD_RAND  = 48;
  localparam int N_REUSE    = 8;
  localparam int N_FLUSH    = 4;
  localparam int TEST_COUNT = 11 * 2 * N_ALU_PER + N_SHIFT + N_MD_DIR + N_MD_RAND +
                              6 * N_REUSE + 3 * N_FLUSH + 1;
  localparam longint WATCHDOG_NS = longint'(TEST_COUNT) * 80 * 20;
  localparam int MD_WAIT = 80;
  localparam logic [`XLEN-1:0] MIN_NEG = {1'b1, {(`XLEN-1){1'b0}}};

  logic             clk;
  logic             rst_n;
  logic [`XLEN-1:0] src1_i;
  logic [`XLEN-1:0] src2_i;
  alu_op_e          alu_op_i;
  logic             word_i;
  logic             muldiv_en_i;
  muldiv_op_e       muldiv_op_i;
  logic             flush_i;
  logic [`XLEN-1:0] result_o;
  logic             less_o;
  logic             zero_o;
  logic             stall_o;

  int               n_checks;
  int               n_errors;

  // expected lock contents of the DUT
  logic             lock_valid;
  logic [`XLEN-1:0] lock_a;
  logic [`XLEN-1:0] lock_b;
  muldiv_op_e       lock_op;

  alu_op_e alu_ops [0:10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_SRC2,
                              ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
  muldiv_op_e md_ops [0:7] = '{MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
                               MD_DIV, MD_DIVU, MD_REM, MD_REMU};

  exec_unit exec_unit_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .alu_op_i    (alu_op_i),
    .word_i      (word_i),
    .muldiv_en_i (muldiv_en_i),
    .muldiv_op_i (muldiv_op_i),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .less_o      (less_o),
    .zero_o      (zero_o),
    .stall_o     (stall_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [`XLEN-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  // random value mixed with signed and 32-bit corners
  function automatic logic [`XLEN-1:0] pick_operand();
    logic [`XLEN-1:0] v;
    case ($urandom_range(0, 9))
      0: v = '0;
      1: v = '1;
      2: v = MIN_NEG;
      3: v = 64'($urandom_range(1, 15));
      4: v = -64'($urandom_range(1, 15));
      5: v = 64'h0000_0000_ffff_ffff;
      6: v = 64'h0000_0000_8000_0000;
      7: v = 64'h0000_0000_7fff_ffff;
      default: v = rand64();
    endcase
    return v;
  endfunction

  function automatic logic [`XLEN-1:0] alu_ref(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                                               input alu_op_e op, input logic w);
    logic [5:0]       sh;
    logic [31:0]      lo;
    logic [`XLEN-1:0] r;
    // word shifts only look at five amount bits
    sh = w ? {1'b0, b[4:0]} : b[5:0];
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_SLL:  r = a << sh;
      ALU_SLT:  r = {63'b0, ($signed(a) < $signed(b))};
      ALU_SLTU: r = {63'b0, (a < b)};
      ALU_SRC2: r = b;
      ALU_XOR:  r = a ^ b;
      ALU_OR:   r = a | b;
      ALU_AND:  r = a & b;
      ALU_SRL: begin
        lo = a[31:0] >> sh;
        r  = w ? {32'b0, lo} : a >> sh;
      end
      ALU_SRA: begin
        lo = $signed(a[31:0]) >>> sh;
        if (w) begin
          r = {32'b0, lo};
        end else begin
          r = $signed(a) >>> sh;
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [`XLEN-1:0] md_ref(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                                              input muldiv_op_e op);
    logic [2*`XLEN-1:0] xa;
    logic [2*`XLEN-1:0] xb;
    logic [2*`XLEN-1:0] prod;
    logic               ovf;
    logic [`XLEN-1:0]   r;
    // extend to 128 bits by signedness, then the full product is exact
    xa   = (op == MD_MULHU) ? {64'b0, a} : {{64{a[63]}}, a};
    xb   = (op == MD_MULH || op == MD_MUL) ? {{64{b[63]}}, b} : {64'b0, b};
    prod = xa * xb;
    ovf  = (a == MIN_NEG) && (b == '1);
    case (op)
      MD_MUL:                       r = prod[63:0];
      MD_MULH, MD_MULHSU, MD_MULHU: r = prod[127:64];
      MD_DIVU: r = (b == '0) ? '1 : a / b;
      MD_REMU: r = (b == '0) ? a : a % b;
      MD_DIV: begin
        if (b == '0) begin
          r = '1;
        end else if (ovf) begin
          r = MIN_NEG;
        end else begin
          r = $signed(a) / $signed(b);
        end
      end
      MD_REM: begin
        if (b == '0) begin
          r = a;
        end else if (ovf) begin
          r = '0;
        end else begin
          r = $signed(a) % $signed(b);
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [`XLEN-1:0] ref_result(input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b,
                                                  input alu_op_e aop, input logic w,
                                                  input logic en, input muldiv_op_e mop);
    logic [`XLEN-1:0] r;
    r = en ? md_ref(a, b, mop) : alu_ref(a, b, aop, w);
    return w ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  // add gives the sign of the true sum, sub and sltu the unsigned compare
  function automatic logic ref_less(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                                    input alu_op_e op);
    logic [`XLEN:0] sum;
    sum = {a[63], a} + {b[63], b};
    if (op == ALU_ADD) begin
      return sum[`XLEN];
    end
    if (op == ALU_SLT) begin
      return $signed(a) < $signed(b);
    end
    return a < b;
  endfunction

  function automatic logic ref_zero(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                                    input alu_op_e op);
    logic [`XLEN-1:0] sum;
    sum = a + b;
    return (op == ALU_ADD) ? (sum == '0) : (a == b);
  endfunction

  task automatic check_val(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                           input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_alu(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                           input alu_op_e op, input logic w);
    @(posedge clk);
    src1_i      <= a;
    src2_i      <= b;
    alu_op_i    <= op;
    word_i      <= w;
    muldiv_en_i <= 1'b0;
    @(negedge clk);
  endtask

  // hold the request until stall_o drops, the compare process checks the result
  task automatic drive_muldiv(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                              input muldiv_op_e op, input logic w);
    logic exp_stall;
    int   n;
    exp_stall = !(lock_valid && a == lock_a && b == lock_b && op == lock_op);
    @(posedge clk);
    src1_i      <= a;
    src2_i      <= b;
    muldiv_op_i <= op;
    word_i      <= w;
    muldiv_en_i <= 1'b1;
    lock_valid = 1'b1;
    lock_a     = a;
    lock_b     = b;
    lock_op    = op;
    @(negedge clk);
    check_val(64'(stall_o), 64'(exp_stall), $sformatf("stall_o in first cycle of %s", op.name()));
    n = 0;
    while (stall_o && n < MD_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (stall_o) begin
      n_errors++;
      $display("%s request did not finish, stall_o still high after %0d cycles", op.name(), n);
    end
  endtask

  task automatic flush_mid_op(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                              input muldiv_op_e op, input int cycles);
    @(posedge clk);
    src1_i      <= a;
    src2_i      <= b;
    muldiv_op_i <= op;
    word_i      <= 1'b0;
    muldiv_en_i <= 1'b1;
    repeat (cycles) @(posedge clk);
    @(negedge clk);
    check_val(64'(stall_o), 64'd1, "stall_o before the operation could finish");
    @(posedge clk);
    flush_i     <= 1'b1;
    muldiv_en_i <= 1'b0;
    @(posedge clk);
    flush_i <= 1'b0;
    lock_valid = 1'b0;
    @(negedge clk);
  endtask

  // outputs settle by the falling edge
  always @(negedge clk) begin
    if (rst_n && !flush_i) begin
      if (!muldiv_en_i) begin
        check_val(64'(stall_o), 64'd0, "stall_o with muldiv_en_i low");
      end
      if (!stall_o) begin
        check_val(result_o,
                  ref_result(src1_i, src2_i, alu_op_i, word_i, muldiv_en_i, muldiv_op_i),
                  $sformatf("%s a=%h b=%h word=%0b",
                            muldiv_en_i ? muldiv_op_i.name() : alu_op_i.name(),
                            src1_i, src2_i, word_i));
        if (!muldiv_en_i && (alu_op_i == ALU_ADD || alu_op_i == ALU_SUB ||
                             alu_op_i == ALU_SLT || alu_op_i == ALU_SLTU)) begin
          check_val(64'(less_o), 64'(ref_less(src1_i, src2_i, alu_op_i)),
                    $sformatf("less_o for %s", alu_op_i.name()));
          check_val(64'(zero_o), 64'(ref_zero(src1_i, src2_i, alu_op_i)),
                    $sformatf("zero_o for %s", alu_op_i.name()));
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the test sequence did not complete", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    muldiv_op_e       op;
    void'($urandom(22));
    n_checks    = 0;
    n_errors    = 0;
    lock_valid  = 1'b0;
    rst_n       = 1'b0;
    src1_i      = '0;
    src2_i      = '0;
    alu_op_i    = ALU_ADD;
    word_i      = 1'b0;
    muldiv_en_i = 1'b0;
    muldiv_op_i = MD_MUL;
    flush_i     = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val(64'(stall_o), 64'd0, "stall_o after reset");

    // every alu op in both modes
    foreach (alu_ops[i]) begin
      for (int w = 0; w < 2; w++) begin
        for (int k = 0; k < N_ALU_PER; k++) begin
          a = pick_operand();
          b = pick_operand();
          if (k == 0 && alu_ops[i] == ALU_SUB) begin
            b = a;
          end
          if (k == 0 && alu_ops[i] == ALU_ADD) begin
            b = -a;
          end
          drive_alu(a, b, alu_ops[i], w[0]);
        end
      end
    end

    // shift amounts 0..63, upper bits of src2 are junk
    for (int amt = 0; amt < 64; amt++) begin
      for (int w = 0; w < 2; w++) begin
        b = rand64();
        b[5:0] = 6'(amt);
        drive_alu(pick_operand(), b, ALU_SLL, w[0]);
        drive_alu(pick_operand(), b, ALU_SRL, w[0]);
        drive_alu(pick_operand(), b, ALU_SRA, w[0]);
      end
    end

    // divide by zero, min by -1 and the signed corners
    foreach (md_ops[i]) begin
      drive_muldiv(rand64(), '0, md_ops[i], 1'b0);
      drive_muldiv(MIN_NEG, '1, md_ops[i], 1'b0);
      drive_muldiv(MIN_NEG, MIN_NEG, md_ops[i], 1'b0);
      drive_muldiv('1, '1, md_ops[i], 1'b0);
    end

    for (int k = 0; k < N_MD_RAND; k++) begin
      drive_muldiv(pick_operand(), pick_operand(), md_ops[$urandom_range(0, 7)],
                   1'($urandom_range(0, 1)));
    end

    // identical requests reuse the locked result, alu ops in between
    for (int k = 0; k < N_REUSE; k++) begin
      a  = pick_operand();
      b  = rand64();
      op = md_ops[$urandom_range(0, 7)];
      drive_muldiv(a, b, op, 1'b0);
      drive_muldiv(a, b, op, 1'b1);
      repeat (3) drive_alu(rand64(), rand64(), alu_ops[$urandom_range(0, 10)],
                           1'($urandom_range(0, 1)));
      drive_muldiv(a, b, op, 1'b0);
    end

    for (int k = 0; k < N_FLUSH; k++) begin
      a  = rand64();
      b  = rand64();
      op = md_ops[$urandom_range(0, 7)];
      flush_mid_op(a, b, op, 5 + 13 * k);
      drive_muldiv(a, b, op, 1'b0);
      drive_muldiv(b, a, md_ops[$urandom_range(0, 7)], 1'b1);
    end

    repeat (2) @(posedge clk);
    $display("tb_exec_unit: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module exec_unit
  import alu_pkg::*, muldiv_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire  [`XLEN-1:0] src1_i,
  input  wire  [`XLEN-1:0] src2_i,
  input  wire  alu_op_e    alu_op_i,
  input  wire              word_i,
  input  wire              muldiv_en_i,
  input  wire  muldiv_op_e muldiv_op_i,
  input  wire              flush_i,
  output logic [`XLEN-1:0] result_o,
  output logic             less_o,
  output logic             zero_o,
  output logic             stall_o
);

  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] mul_res;
  logic [`XLEN-1:0] div_res;
  logic [`XLEN-1:0] raw_res;
  logic [`XLEN-1:0] lk_src1_q;
  logic [`XLEN-1:0] lk_src2_q;
  muldiv_op_e       lk_op_q;
  logic             lk_valid_q;
  logic             done_q;
  logic             match;
  logic             start;
  logic             mul_start;
  logic             div_start;
  logic             mul_done;
  logic             div_done;

  alu_core alu_i (
    .src1_i (src1_i),
    .src2_i (src2_i),
    .op_i   (alu_op_i),
    .word_i (word_i),
    .alu_o  (alu_res),
    .less_o (less_o),
    .zero_o (zero_o)
  );

  // request already locked, a new one starts a unit
  assign match = lk_valid_q && (src1_i == lk_src1_q) && (src2_i == lk_src2_q) &&
                 (muldiv_op_i == lk_op_q);
  assign start     = muldiv_en_i && !match && !flush_i;
  assign mul_start = start && !muldiv_op_i[2];
  assign div_start = start && muldiv_op_i[2];

  // the done pulse counts as finished in its own cycle
  assign stall_o = muldiv_en_i && !(match && (done_q || mul_done || div_done));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lk_valid_q <= 1'b0;
      done_q     <= 1'b0;
    end else if (flush_i) begin
      lk_valid_q <= 1'b0;
      done_q     <= 1'b0;
    end else if (start) begin
      lk_valid_q <= 1'b1;
      done_q     <= 1'b0;
    end else if (mul_done || div_done) begin
      done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      lk_src1_q <= src1_i;
      lk_src2_q <= src2_i;
      lk_op_q   <= muldiv_op_i;
    end
  end

  // starting one unit cancels whatever the other is doing
  mul_unit mul_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (mul_start),
    .abort_i  (flush_i | div_start),
    .op_i     (muldiv_op_i),
    .a_i      (src1_i),
    .b_i      (src2_i),
    .done_o   (mul_done),
    .result_o (mul_res)
  );

  div_unit div_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (div_start),
    .abort_i  (flush_i | mul_start),
    .op_i     (muldiv_op_i),
    .a_i      (src1_i),
    .b_i      (src2_i),
    .done_o   (div_done),
    .result_o (div_res)
  );

  assign raw_res  = muldiv_en_i ? (muldiv_op_i[2] ? div_res : mul_res) : alu_res;
  assign result_o = word_i ? {{(`XLEN/2){raw_res[31]}}, raw_res[31:0]} : raw_res;

endmodule

`default_nettype wire

/* div_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module div_unit
  import muldiv_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              start_i,
  input  wire              abort_i,
  input  wire  muldiv_op_e op_i,
  input  wire  [`XLEN-1:0] a_i,
  input  wire  [`XLEN-1:0] b_i,
  output logic             done_o,
  output logic [`XLEN-1:0] result_o
);

  localparam int CNT_W = $clog2(`MULDIV_ITER);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MULDIV_ITER - 1);
  localparam logic [`XLEN-1:0] MIN_NEG = {1'b1, {(`XLEN-1){1'b0}}};

  iter_state_e      state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             done_q;
  muldiv_op_e       op_q;
  logic             qneg_q;
  logic             rneg_q;
  logic             div0_q;
  logic             ovf_q;
  logic [`XLEN-1:0] divisor_q;
  logic [`XLEN-1:0] rem_q;
  logic [`XLEN-1:0] quo_q;
  logic [`XLEN-1:0] result_q;
  logic             a_neg;
  logic             b_neg;
  logic [`XLEN-1:0] mag_a;
  logic [`XLEN-1:0] mag_b;
  logic [`XLEN:0]   trial;
  logic [`XLEN:0]   diff;
  logic [`XLEN-1:0] q_fix;
  logic [`XLEN-1:0] r_fix;

  assign a_neg = md_a_signed(op_i) & a_i[`XLEN-1];
  assign b_neg = md_b_signed(op_i) & b_i[`XLEN-1];
  assign mag_a = a_neg ? -a_i : a_i;
  assign mag_b = b_neg ? -b_i : b_i;

  // bring in the next dividend bit and try the subtract
  assign trial = {rem_q, quo_q[`XLEN-1]};
  assign diff  = trial - {1'b0, divisor_q};

  // divide by zero gives all ones, min / -1 gives min with zero remainder
  assign q_fix = div0_q ? {`XLEN{1'b1}} :
                 ovf_q  ? MIN_NEG :
                 qneg_q ? -quo_q : quo_q;
  assign r_fix = ovf_q  ? {`XLEN{1'b0}} :
                 rneg_q ? -rem_q : rem_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (abort_i) begin
        state_q <= IDLE;
      end else if (start_i) begin
        state_q <= RUN;
        cnt_q   <= '0;
      end else begin
        case (state_q)
          RUN: begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_LAST) begin
              state_q <= DONE;
            end
          end
          DONE: begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      op_q      <= op_i;
      qneg_q    <= a_neg ^ b_neg;
      rneg_q    <= a_neg;
      div0_q    <= (b_i == {`XLEN{1'b0}});
      ovf_q     <= md_a_signed(op_i) && (a_i == MIN_NEG) && (b_i == {`XLEN{1'b1}});
      divisor_q <= mag_b;
      rem_q     <= '0;
      quo_q     <= mag_a;
    end else if (state_q == RUN) begin
      // negative difference means restore, quotient bit 0
      rem_q <= diff[`XLEN] ? trial[`XLEN-1:0] : diff[`XLEN-1:0];
      quo_q <= {quo_q[`XLEN-2:0], ~diff[`XLEN]};
    end else if (state_q == DONE) begin
      result_q <= op_q[1] ? r_fix : q_fix;
    end
  end

  assign done_o   = done_q;
  assign result_o = result_q;

endmodule

`default_nettype wire

/* mul_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module mul_unit
  import muldiv_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              start_i,
  input  wire              abort_i,
  input  wire  muldiv_op_e op_i,
  input  wire  [`XLEN-1:0] a_i,
  input  wire  [`XLEN-1:0] b_i,
  output logic             done_o,
  output logic [`XLEN-1:0] result_o
);

  localparam int CNT_W = $clog2(`MULDIV_ITER);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MULDIV_ITER - 1);

  iter_state_e        state_q;
  logic [CNT_W-1:0]   cnt_q;
  logic               done_q;
  muldiv_op_e         op_q;
  logic               neg_q;
  logic [`XLEN-1:0]   mcand_q;
  logic [2*`XLEN-1:0] prod_q;
  logic [`XLEN-1:0]   result_q;
  logic               a_neg;
  logic               b_neg;
  logic [`XLEN-1:0]   mag_a;
  logic [`XLEN-1:0]   mag_b;
  logic [`XLEN:0]     psum;
  logic [2*`XLEN-1:0] prod_fix;

  assign a_neg = md_a_signed(op_i) & a_i[`XLEN-1];
  assign b_neg = md_b_signed(op_i) & b_i[`XLEN-1];
  assign mag_a = a_neg ? -a_i : a_i;
  assign mag_b = b_neg ? -b_i : b_i;

  // add multiplicand into the high half when the low bit is set
  assign psum = {1'b0, prod_q[2*`XLEN-1:`XLEN]} +
                (prod_q[0] ? {1'b0, mcand_q} : {(`XLEN+1){1'b0}});

  assign prod_fix = neg_q ? -prod_q : prod_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (abort_i) begin
        state_q <= IDLE;
      end else if (start_i) begin
        state_q <= RUN;
        cnt_q   <= '0;
      end else begin
        case (state_q)
          RUN: begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_LAST) begin
              state_q <= DONE;
            end
          end
          DONE: begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      op_q    <= op_i;
      neg_q   <= a_neg ^ b_neg;
      mcand_q <= mag_a;
      prod_q  <= {{`XLEN{1'b0}}, mag_b};
    end else if (state_q == RUN) begin
      prod_q <= {psum, prod_q[`XLEN-1:1]};
    end else if (state_q == DONE) begin
      // mul keeps the low half, the mulh family the high half
      result_q <= (op_q == MD_MUL) ? prod_fix[`XLEN-1:0] : prod_fix[2*`XLEN-1:`XLEN];
    end
  end

  assign done_o   = done_q;
  assign result_o = result_q;

endmodule

`default_nettype wire

/* alu_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module alu_core
  import alu_pkg::*;
(
  input  wire  [`XLEN-1:0] src1_i,
  input  wire  [`XLEN-1:0] src2_i,
  input  wire  alu_op_e    op_i,
  input  wire              word_i,
  output logic [`XLEN-1:0] alu_o,
  output logic             less_o,
  output logic             zero_o
);

  logic             sub;
  logic [`XLEN-1:0] src2_x;
  logic [`XLEN-1:0] sum;
  logic             carry;
  logic             overflow;
  logic [`XLEN-1:0] shift;

  // subtract is add of the inverted operand plus one
  assign sub    = alu_sub(op_i);
  assign src2_x = src2_i ^ {`XLEN{sub}};

  assign {carry, sum} = {1'b0, src1_i} + {1'b0, src2_x} + {{`XLEN{1'b0}}, sub};

  assign overflow = (src1_i[`XLEN-1] == src2_x[`XLEN-1]) &&
                    (sum[`XLEN-1] != src1_i[`XLEN-1]);

  // unsigned less is the borrow, signed less is sign xor overflow
  assign less_o = alu_mod(op_i) ? (carry ^ sub) : (sum[`XLEN-1] ^ overflow);
  assign zero_o = ~|sum;

  alu_shifter shifter_i (
    .src_i   (src1_i),
    .shamt_i (src2_i[5:0]),
    .right_i (op_i[2]),
    .arith_i (alu_mod(op_i)),
    .word_i  (word_i),
    .shift_o (shift)
  );

  always_comb begin
    case (alu_sel(op_i))
      SEL_ADD: begin
        alu_o = sum;
      end
      SEL_SLL, SEL_SHR: begin
        alu_o = shift;
      end
      SEL_SLT: begin
        alu_o = {{(`XLEN-1){1'b0}}, less_o};
      end
      SEL_SRC2: begin
        alu_o = src2_i;
      end
      SEL_XOR: begin
        alu_o = src1_i ^ src2_i;
      end
      SEL_OR: begin
        alu_o = src1_i | src2_i;
      end
      SEL_AND: begin
        alu_o = src1_i & src2_i;
      end
      default: begin
        alu_o = sum;
      end
    endcase
  end

endmodule

`default_nettype wire

/* alu_shifter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module alu_shifter (
  input  wire  [`XLEN-1:0] src_i,
  input  wire  [5:0]       shamt_i,
  input  wire              right_i,
  input  wire              arith_i,
  input  wire              word_i,
  output logic [`XLEN-1:0] shift_o
);

  logic [5:0]       amt;
  logic [`XLEN-1:0] src_x;
  logic [`XLEN-1:0] shft_res;
  logic [`XLEN-1:0] sr_mask;
  logic [`XLEN-1:0] word_mask;
  logic [`XLEN-1:0] srl_res;
  logic [`XLEN-1:0] sra_res;
  logic [`XLEN-1:0] sll_res;

  function automatic logic [`XLEN-1:0] bit_rev(input logic [`XLEN-1:0] v);
    logic [`XLEN-1:0] r;
    for (int i = 0; i < `XLEN; i++) begin
      r[i] = v[`XLEN-1-i];
    end
    return r;
  endfunction

  // word shifts use only five amount bits
  assign amt = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;

  // left shift is a right shift of the reversed source
  assign src_x    = right_i ? src_i : bit_rev(src_i);
  assign shft_res = src_x >> amt;
  assign sr_mask  = {`XLEN{1'b1}} >> amt;

  // low 32 - amt bits hold source data in word mode
  assign word_mask = {32'b0, sr_mask[`XLEN-1:`XLEN/2]};

  assign srl_res = word_i ? (shft_res & word_mask) : shft_res;
  assign sra_res = word_i ?
                   (srl_res | ({`XLEN{src_i[31]}} & {32'b0, ~sr_mask[`XLEN-1:`XLEN/2]})) :
                   (shft_res | ({`XLEN{src_i[`XLEN-1]}} & ~sr_mask));
  assign sll_res = bit_rev(shft_res);

  assign shift_o = right_i ? (arith_i ? sra_res : srl_res) : sll_res;

endmodule

`default_nettype wire

/* muldiv_pkg.sv */
`default_nettype none

package muldiv_pkg;

  // bit 2 selects divide, bits 1:0 the variant
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } muldiv_op_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } iter_state_e;

  // operand a is signed for all but mulhu, divu, remu
  function automatic logic md_a_signed(muldiv_op_e op);
    if (op[2]) begin
      return ~op[0];
    end
    return op[1:0] != 2'b11;
  endfunction

  function automatic logic md_b_signed(muldiv_op_e op);
    if (op[2]) begin
      return ~op[0];
    end
    return ~op[1];
  endfunction

endpackage

`default_nettype wire

/* alu_pkg.sv */
`default_nettype none

package alu_pkg;

  // bit 3 modifies (sub, unsigned, arith), bits 2:0 pick the function
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b1010,
    ALU_SRC2 = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  // result select codes
  localparam logic [2:0] SEL_ADD  = 3'd0;
  localparam logic [2:0] SEL_SLL  = 3'd1;
  localparam logic [2:0] SEL_SLT  = 3'd2;
  localparam logic [2:0] SEL_SRC2 = 3'd3;
  localparam logic [2:0] SEL_XOR  = 3'd4;
  localparam logic [2:0] SEL_SHR  = 3'd5;
  localparam logic [2:0] SEL_OR   = 3'd6;
  localparam logic [2:0] SEL_AND  = 3'd7;

  function automatic logic [2:0] alu_sel(alu_op_e op);
    return op[2:0];
  endfunction

  function automatic logic alu_mod(alu_op_e op);
    return op[3];
  endfunction

  // slt/sltu compare through the subtractor as well
  function automatic logic alu_sub(alu_op_e op);
    return op[3] | op[1];
  endfunction

endpackage

`default_nettype wire

/* alu_cfg.svh */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// datapath width, fixed by the op encodings
`define XLEN 64

// shift-add or restoring steps per mul/div
`define MULDIV_ITER 64

`endif
